/* dmr_defines.svh */
/*
 * Build-time constants of the DMR control unit: bus widths, register map
 * and the rapid recovery feature switch. Include it wherever a macro is used.
 */

`ifndef DMR_DEFINES_SVH
`define DMR_DEFINES_SVH

// Compared output bus of one core
`define DMR_DATA_W 32

// Register bus geometry
`define DMR_REG_W  32
`define DMR_ADDR_W 4

// Saturating mismatch counter
`define DMR_CNT_W  8

// Word aligned register addresses
`define DMR_ADDR_ENABLE   4'h0
`define DMR_ADDR_CONFIG   4'h4
`define DMR_ADDR_MISMATCH 4'h8
`define DMR_ADDR_STATUS   4'hC

// Setting this to 1'b0 builds the unit without rapid recovery
`define DMR_RAPID_RECOVERY 1'b1

`endif

/* dmr_pkg.sv */
/*
 * Types shared by the DMR control unit blocks and its testbench.
 * Import with dmr_pkg::* in the module header.
 */

`default_nettype none

`include "dmr_defines.svh"

package dmr_pkg;

  // Vectors with a meaning of their own
  typedef logic [`DMR_DATA_W-1:0] dmr_data_t;
  typedef logic [`DMR_ADDR_W-1:0] reg_addr_t;
  typedef logic [`DMR_REG_W-1:0]  reg_data_t;
  typedef logic [`DMR_CNT_W-1:0]  mism_cnt_t;

  // Redundancy mode of the core pair
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // One core's compared outputs
  typedef struct packed {
    logic      valid;
    dmr_data_t data;
  } core_out_t;

  // Configuration bits from the register file to the FSM
  typedef struct packed {
    logic enable;
    logic rapid_recovery;
    logic force_recovery;
  } dmr_cfg_t;

  // Status and update pulses from the FSM to the register file
  typedef struct packed {
    logic      force_ack;
    logic      incr_mismatch;
    dmr_mode_e mode;
  } dmr_hw2reg_t;

endpackage

`default_nettype wire

/* dmr_regs.sv */
/*
 * Configuration and status registers of the DMR unit. Writes land on any
 * edge with reg_we_i high and reads follow reg_addr_i combinationally.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module dmr_regs import dmr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Register bus
  input  logic        reg_we_i,
  input  reg_addr_t   reg_addr_i,
  input  reg_data_t   reg_wdata_i,
  output reg_data_t   reg_rdata_o,

  // Hardware side
  input  dmr_hw2reg_t hw2reg_i,
  output dmr_cfg_t    cfg_o
);

  localparam bit RapidRecovery = `DMR_RAPID_RECOVERY;

  logic      enable_q;
  logic      rapid_q;
  logic      force_q;
  mism_cnt_t cnt_q;

  // Address decode of the write strobe
  logic we_enable;
  logic we_config;
  logic we_mismatch;

  assign we_enable   = reg_we_i && (reg_addr_i == `DMR_ADDR_ENABLE);
  assign we_config   = reg_we_i && (reg_addr_i == `DMR_ADDR_CONFIG);
  assign we_mismatch = reg_we_i && (reg_addr_i == `DMR_ADDR_MISMATCH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      rapid_q  <= 1'b0;
      force_q  <= 1'b0;
    end else begin
      if (we_enable) begin
        enable_q <= reg_wdata_i[0];
      end
      // Rapid recovery bit is tied off when the feature is not built
      if (we_config) begin
        rapid_q <= reg_wdata_i[0] && RapidRecovery;
      end
      // Software write takes priority over the hardware acknowledge
      if (we_config) begin
        force_q <= reg_wdata_i[1];
      end else if (hw2reg_i.force_ack) begin
        force_q <= 1'b0;
      end
    end
  end

  // Mismatch counter that any write clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (we_mismatch) begin
      cnt_q <= '0;
    end else if (hw2reg_i.incr_mismatch && (cnt_q != '1)) begin
      // Stops at all ones
      cnt_q <= cnt_q + mism_cnt_t'(1);
    end
  end

  // Read mux with zero for unmapped addresses
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `DMR_ADDR_ENABLE: begin
        reg_rdata_o[0] = enable_q;
      end
      `DMR_ADDR_CONFIG: begin
        reg_rdata_o[0] = rapid_q;
        reg_rdata_o[1] = force_q;
      end
      `DMR_ADDR_MISMATCH: begin
        reg_rdata_o = reg_data_t'(cnt_q);
      end
      `DMR_ADDR_STATUS: begin
        // Current mode straight from the FSM
        reg_rdata_o = reg_data_t'(hw2reg_i.mode);
      end
      default: begin
        reg_rdata_o = '0;
      end
    endcase
  end

  // Configuration to the mode FSM
  assign cfg_o.enable         = enable_q;
  assign cfg_o.rapid_recovery = rapid_q;
  assign cfg_o.force_recovery = force_q;

endmodule

`default_nettype wire

/* dmr_lockstep_cmp.sv */
/*
 * Lockstep comparator for the two cores' output buses. A mismatch seen at
 * an edge shows up as error_o during the following cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module dmr_lockstep_cmp import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_out_t core_a_i,
  input  core_out_t core_b_i,
  output logic      error_o
);

  logic valid_diff;
  logic data_diff;
  logic error_q;

  // One core valid and the other not counts as a mismatch
  assign valid_diff = core_a_i.valid != core_b_i.valid;

  // Data only matters when both cores present a result
  assign data_diff = core_a_i.valid && core_b_i.valid &&
                     (core_a_i.data != core_b_i.data);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q <= 1'b0;
    end else begin
      error_q <= valid_diff || data_diff;
    end
  end

  assign error_o = error_q;

endmodule

`default_nettype wire

/* dmr_mode_ctrl.sv */
/*
 * Mode FSM of the core pair with independent, lockstep run and restore modes.
 * On a lockstep error it starts rapid recovery or asks software to resync.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module dmr_mode_ctrl import dmr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Configuration from the register file
  input  dmr_cfg_t    cfg_i,

  // Comparator and core status
  input  logic        error_i,
  input  logic        fetch_en_i,
  input  logic        cores_synch_i,
  input  logic        recovery_finished_i,

  // Pulses and mode back to the register file
  output dmr_hw2reg_t hw2reg_o,

  // Control outputs
  output logic        sw_resynch_req_o,
  output logic        recovery_request_o,
  output logic        grp_in_independent_o,
  output logic        rapid_recovery_en_o
);

  localparam bit RapidRecovery = `DMR_RAPID_RECOVERY;

  dmr_mode_e mode_d;
  dmr_mode_e mode_q;
  logic      rapid_en;
  logic      force_ack;
  logic      incr_mismatch;

  // Rapid recovery only counts when the feature is built in
  assign rapid_en = cfg_i.rapid_recovery && RapidRecovery;

  always_comb begin
    mode_d             = mode_q;
    force_ack          = 1'b0;
    incr_mismatch      = 1'b0;
    sw_resynch_req_o   = 1'b0;
    recovery_request_o = 1'b0;

    case (mode_q)
      DMR_RUN: begin
        // Software forced restore
        if (cfg_i.force_recovery && rapid_en) begin
          force_ack = 1'b1;
          mode_d    = DMR_RESTORE;
        end
        // Count a lockstep error and pick the recovery path
        if (error_i) begin
          incr_mismatch = 1'b1;
          if (rapid_en) begin
            mode_d = DMR_RESTORE;
          end else begin
            sw_resynch_req_o = 1'b1;
          end
        end
      end
      DMR_RESTORE: begin
        // Level request until the recovery agent answers
        recovery_request_o = 1'b1;
        if (recovery_finished_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: begin
        mode_d = mode_q;
      end
    endcase

    // Before fetch starts the enable bit alone picks the mode
    if (!fetch_en_i) begin
      mode_d = cfg_i.enable ? DMR_RUN : NON_DMR;
    end

    // Leaving lockstep is allowed at any time
    if ((mode_q == DMR_RUN) && !cfg_i.enable) begin
      mode_d = NON_DMR;
    end

    // Entry needs the cores in a synchronised state
    if ((mode_q == NON_DMR) && cores_synch_i && cfg_i.enable) begin
      mode_d = DMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= NON_DMR;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign grp_in_independent_o = mode_q == NON_DMR;
  assign rapid_recovery_en_o  = rapid_en;

  // Feedback for the register file
  assign hw2reg_o.force_ack     = force_ack;
  assign hw2reg_o.incr_mismatch = incr_mismatch;
  assign hw2reg_o.mode          = mode_q;

endmodule

`default_nettype wire

/* dmr_unit.sv */
/*
 * Top level of the DMR control unit. Ties the register file, the lockstep
 * comparator and the mode FSM together for one pair of cores.
 */

`timescale 1ns/1ps
`default_nettype none

module dmr_unit import dmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Register bus
  input  logic      reg_we_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,

  // Core output buses under comparison
  input  core_out_t core_a_i,
  input  core_out_t core_b_i,

  // Core and recovery agent status
  input  logic      fetch_en_i,
  input  logic      cores_synch_i,
  input  logic      recovery_finished_i,

  // Control outputs
  output logic      sw_resynch_req_o,
  output logic      recovery_request_o,
  output logic      grp_in_independent_o,
  output logic      rapid_recovery_en_o
);

  dmr_cfg_t    cfg;
  dmr_hw2reg_t hw2reg;
  logic        cmp_error;

  dmr_regs i_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .hw2reg_i    (hw2reg),
    .cfg_o       (cfg)
  );

  dmr_lockstep_cmp i_cmp (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .core_a_i (core_a_i),
    .core_b_i (core_b_i),
    .error_o  (cmp_error)
  );

  dmr_mode_ctrl i_mode_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cfg_i                (cfg),
    .error_i              (cmp_error),
    .fetch_en_i           (fetch_en_i),
    .cores_synch_i        (cores_synch_i),
    .recovery_finished_i  (recovery_finished_i),
    .hw2reg_o             (hw2reg),
    .sw_resynch_req_o     (sw_resynch_req_o),
    .recovery_request_o   (recovery_request_o),
    .grp_in_independent_o (grp_in_independent_o),
    .rapid_recovery_en_o  (rapid_recovery_en_o)
  );

endmodule

`default_nettype wire

/* dmr_sva.sv */
/*
 * Concurrent checks on the DMR unit top level, bound into dmr_unit.
 */

`timescale 1ns/1ps
`default_nettype none

module dmr_sva import dmr_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input dmr_mode_e mode_i,
  input logic      force_ack_i,
  input logic      recovery_request_i,
  input logic      sw_resynch_req_i,
  input logic      rapid_recovery_en_i
);

  // Recovery is only requested while restoring
  req_in_restore: assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_request_i |-> (mode_i == DMR_RESTORE))
    else $error("recovery request outside DMR_RESTORE");

  // Software resync and rapid recovery exclude each other
  no_resynch_in_rapid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_resynch_req_i |-> !rapid_recovery_en_i)
    else $error("software resync while rapid recovery is enabled");

  // Acknowledge of a forced recovery lasts one cycle
  ack_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    force_ack_i |=> !force_ack_i)
    else $error("force_ack held longer than one cycle");

endmodule

bind dmr_unit dmr_sva i_sva (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .mode_i              (hw2reg.mode),
  .force_ack_i         (hw2reg.force_ack),
  .recovery_request_i  (recovery_request_o),
  .sw_resynch_req_i    (sw_resynch_req_o),
  .rapid_recovery_en_i (rapid_recovery_en_o)
);

`default_nettype wire

/* dmr_tb.sv */
/*
 * Testbench of the DMR unit. LFSR driven core traffic and register writes
 * with every output and register read checked against a cycle model.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module dmr_tb import dmr_pkg::*; ();

  localparam bit RapidBuilt = `DMR_RAPID_RECOVERY;
  localparam int ReqTimeout = 8;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        reg_we;
  reg_addr_t   reg_addr;
  reg_data_t   reg_wdata;
  reg_data_t   reg_rdata;
  core_out_t   core_a;
  core_out_t   core_b;
  logic        fetch_en;
  logic        cores_synch;
  logic        rec_finished;
  logic        sw_resynch;
  logic        rec_request;
  logic        independent;
  logic        rapid_en;

  // Model state and what it predicts for the coming edge
  logic        m_enable, m_rapid, m_force, m_err;
  mism_cnt_t   m_cnt;
  dmr_mode_e   m_mode;
  dmr_mode_e   e_next;
  logic        e_sw, e_incr, e_ack;
  logic [31:0] lfsr;
  int          checks, errors, test_errors;

  dmr_unit dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .reg_we_i             (reg_we),
    .reg_addr_i           (reg_addr),
    .reg_wdata_i          (reg_wdata),
    .reg_rdata_o          (reg_rdata),
    .core_a_i             (core_a),
    .core_b_i             (core_b),
    .fetch_en_i           (fetch_en),
    .cores_synch_i        (cores_synch),
    .recovery_finished_i  (rec_finished),
    .sw_resynch_req_o     (sw_resynch),
    .recovery_request_o   (rec_request),
    .grp_in_independent_o (independent),
    .rapid_recovery_en_o  (rapid_en)
  );

  always #50 clk_i = ~clk_i;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
    end
    return r;
  endfunction

  function automatic reg_data_t model_read(input reg_addr_t addr);
    case (addr)
      `DMR_ADDR_ENABLE:   return reg_data_t'(m_enable);
      `DMR_ADDR_CONFIG:   return reg_data_t'({m_force, m_rapid});
      `DMR_ADDR_MISMATCH: return reg_data_t'(m_cnt);
      `DMR_ADDR_STATUS:   return reg_data_t'(m_mode);
      default:            return '0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Mode rules in order so that later ones win
  task automatic model_comb();
    e_next = m_mode;
    e_sw   = 1'b0;
    e_incr = 1'b0;
    e_ack  = 1'b0;
    if (m_mode == DMR_RUN) begin
      if (m_force && m_rapid) begin
        e_ack  = 1'b1;
        e_next = DMR_RESTORE;
      end
      if (m_err) begin
        e_incr = 1'b1;
        if (m_rapid) e_next = DMR_RESTORE;
        else e_sw = 1'b1;
      end
    end
    if ((m_mode == DMR_RESTORE) && rec_finished) e_next = DMR_RUN;
    if (!fetch_en) e_next = m_enable ? DMR_RUN : NON_DMR;
    if ((m_mode == DMR_RUN) && !m_enable) e_next = NON_DMR;
    if ((m_mode == NON_DMR) && cores_synch && m_enable) e_next = DMR_RUN;
  endtask

  task automatic model_edge();
    if (!rst_ni) begin
      {m_enable, m_rapid, m_force, m_err} = '0;
      m_cnt  = '0;
      m_mode = NON_DMR;
    end else begin
      if (reg_we && (reg_addr == `DMR_ADDR_ENABLE)) m_enable = reg_wdata[0];
      if (reg_we && (reg_addr == `DMR_ADDR_CONFIG)) begin
        m_rapid = reg_wdata[0] && RapidBuilt;
        m_force = reg_wdata[1];
      end else if (e_ack) m_force = 1'b0;
      if (reg_we && (reg_addr == `DMR_ADDR_MISMATCH)) m_cnt = '0;
      else if (e_incr && (m_cnt != 8'hFF)) m_cnt = m_cnt + 8'd1;
      // Comparator sees one-sided valid or differing data of a valid pair
      m_err = (core_a.valid != core_b.valid) ||
              (core_a.valid && core_b.valid && (core_a.data != core_b.data));
      m_mode = e_next;
    end
  endtask

  // Checks outputs mid-cycle and updates the model at the edge before returning 1 ns after it
  task automatic cycle();
    @(negedge clk_i);
    model_comb();
    compare("grp_in_independent_o", 32'(m_mode == NON_DMR), 32'(independent));
    compare("recovery_request_o", 32'(m_mode == DMR_RESTORE), 32'(rec_request));
    compare("sw_resynch_req_o", 32'(e_sw), 32'(sw_resynch));
    compare("rapid_recovery_en_o", 32'(m_rapid), 32'(rapid_en));
    compare("reg_rdata_o", model_read(reg_addr), reg_rdata);
    @(posedge clk_i);
    model_edge();
    #1;
  endtask

  task automatic idle(input int n);
    core_a = '0;
    core_b = '0;
    repeat (n) cycle();
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    cycle();
    reg_we = 1'b0;
  endtask

  task automatic reg_expect(input reg_addr_t addr, input reg_data_t exp, input string name);
    reg_addr = addr;
    #1;
    compare(name, exp, reg_rdata);
    cycle();
  endtask

  task automatic drive_cores(input logic mism);
    logic [31:0] data;
    logic [4:0]  pos;
    logic        both;
    data = rand_bits(32);
    pos  = 5'(rand_bits(5));
    both = rand_bits(2) != 0;
    core_a.valid = both;
    core_a.data  = data;
    core_b       = core_a;
    // Idle pair with different data must not count
    if (!both) core_b.data = ~data;
    if (mism && both && (rand_bits(1) != 0)) core_b.data[pos] = ~data[pos];
    else if (mism) core_b.valid = !both;
  endtask

  task automatic end_run();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic wait_request(input logic level);
    int n;
    n = 0;
    while ((rec_request !== level) && (n < ReqTimeout)) begin
      cycle();
      n++;
    end
    if (rec_request !== level) begin
      errors++;
      $display("Timeout: recovery_request_o never went to %0b", level);
      end_run();
    end
  endtask

  task automatic test_done(input string name);
    $display("Test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // Answer one recovery request after a random delay
  task automatic finish_recovery();
    repeat (rand_bits(3) + 1) cycle();
    rec_finished = 1'b1;
    cycle();
    rec_finished = 1'b0;
    wait_request(1'b0);
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(DMR_RUN), "STATUS");
  endtask

  initial begin
    logic [31:0] rnd;
    logic        en_bit;
    lfsr = 32'h1c462e68;
    {checks, errors, test_errors} = '0;
    {rst_ni, reg_we, fetch_en, cores_synch, rec_finished} = '0;
    reg_addr  = `DMR_ADDR_STATUS;
    reg_wdata = '0;
    core_a    = '0;
    core_b    = '0;
    {m_enable, m_rapid, m_force, m_err} = '0;
    m_cnt  = '0;
    m_mode = NON_DMR;
    repeat (3) cycle();
    rst_ni = 1'b1;

    // Reset values, random writes, read-only STATUS and unmapped holes
    reg_expect(`DMR_ADDR_ENABLE, '0, "ENABLE");
    reg_expect(`DMR_ADDR_CONFIG, '0, "CONFIG");
    reg_expect(`DMR_ADDR_MISMATCH, '0, "MISMATCH");
    reg_expect(`DMR_ADDR_STATUS, '0, "STATUS");
    for (int i = 0; i < 8; i++) begin
      rnd = rand_bits(32);
      en_bit = rnd[0];
      reg_write(`DMR_ADDR_ENABLE, rnd);
      reg_expect(`DMR_ADDR_ENABLE, {31'b0, en_bit}, "ENABLE");
      rnd = rand_bits(32);
      reg_write(`DMR_ADDR_CONFIG, rnd);
      reg_expect(`DMR_ADDR_CONFIG, {30'b0, rnd[1], rnd[0] & RapidBuilt}, "CONFIG");
      reg_write(`DMR_ADDR_STATUS, rand_bits(32));
      // Mode follows the enable bit alone while fetch is off
      reg_expect(`DMR_ADDR_STATUS, reg_data_t'(en_bit ? DMR_RUN : NON_DMR), "STATUS");
      rnd = rand_bits(32);
      reg_write({rnd[1:0], 2'b01}, rand_bits(32));
      reg_expect({rnd[1:0], 2'b01}, '0, "unmapped");
    end
    reg_write(`DMR_ADDR_ENABLE, '0);
    reg_write(`DMR_ADDR_CONFIG, '0);
    idle(2);
    test_done("register access");

    // Without fetch the enable bit alone picks the mode
    reg_write(`DMR_ADDR_ENABLE, 32'h1);
    cycle();
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(DMR_RUN), "STATUS");
    reg_write(`DMR_ADDR_ENABLE, '0);
    cycle();
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(NON_DMR), "STATUS");
    // With fetch running, entry waits for synchronised cores
    fetch_en = 1'b1;
    reg_write(`DMR_ADDR_ENABLE, 32'h1);
    idle(3);
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(NON_DMR), "STATUS");
    cores_synch = 1'b1;
    cycle();
    cores_synch = 1'b0;
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(DMR_RUN), "STATUS");
    reg_write(`DMR_ADDR_ENABLE, '0);
    cycle();
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(NON_DMR), "STATUS");
    test_done("mode entry and exit");

    // Lockstep traffic with software resync and then saturation
    reg_write(`DMR_ADDR_ENABLE, 32'h1);
    cores_synch = 1'b1;
    cycle();
    cores_synch = 1'b0;
    reg_write(`DMR_ADDR_MISMATCH, '0);
    for (int i = 0; i < 200; i++) begin
      drive_cores(rand_bits(1) != 0);
      cycle();
    end
    idle(2);
    reg_write(`DMR_ADDR_MISMATCH, rand_bits(32));
    reg_expect(`DMR_ADDR_MISMATCH, '0, "MISMATCH");
    for (int i = 0; i < 270; i++) begin
      drive_cores(1'b1);
      cycle();
    end
    idle(2);
    reg_expect(`DMR_ADDR_MISMATCH, 32'hFF, "MISMATCH");
    reg_write(`DMR_ADDR_MISMATCH, '0);
    // Errors in independent mode are neither counted nor reported
    reg_write(`DMR_ADDR_ENABLE, '0);
    for (int i = 0; i < 40; i++) begin
      drive_cores(rand_bits(1) != 0);
      cycle();
    end
    idle(2);
    reg_expect(`DMR_ADDR_MISMATCH, '0, "MISMATCH");
    test_done("lockstep traffic");

    reg_write(`DMR_ADDR_ENABLE, 32'h1);
    cores_synch = 1'b1;
    cycle();
    cores_synch = 1'b0;
    if (RapidBuilt) begin
      reg_write(`DMR_ADDR_CONFIG, 32'h1);
      for (int i = 0; i < 4; i++) begin
        repeat (rand_bits(3) + 1) begin
          drive_cores(1'b0);
          cycle();
        end
        drive_cores(1'b1);
        cycle();
        idle(0);
        wait_request(1'b1);
        reg_expect(`DMR_ADDR_STATUS, reg_data_t'(DMR_RESTORE), "STATUS");
        finish_recovery();
      end
      test_done("rapid recovery");

      // Forced restore clears its own bit
      reg_write(`DMR_ADDR_CONFIG, 32'h3);
      cycle();
      reg_expect(`DMR_ADDR_CONFIG, 32'h1, "CONFIG");
      wait_request(1'b1);
      finish_recovery();
    end
    // Without rapid recovery the force bit just stays set
    reg_write(`DMR_ADDR_CONFIG, 32'h2);
    idle(3);
    reg_expect(`DMR_ADDR_CONFIG, 32'h2, "CONFIG");
    reg_expect(`DMR_ADDR_STATUS, reg_data_t'(DMR_RUN), "STATUS");
    reg_write(`DMR_ADDR_CONFIG, '0);
    idle(2);
    test_done("forced recovery");

    end_run();
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
dmr_pkg.sv
dmr_regs.sv
dmr_lockstep_cmp.sv
dmr_mode_ctrl.sv
dmr_unit.sv
dmr_sva.sv
dmr_tb.sv

/* Makefile */
# Verilator build and run of the DMR unit testbench

TOP = dmr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module dmr_unit

clean:
	rm -rf obj_dir sim.log
